//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_u2_ctrl
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; fi

lint:
	$(SIM) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_u2_ctrl.sv
////////////////////////////////////////////////////////////
// Board control slice testbench
// Drives the host bus and checks pins, readback and interrupts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_u2_ctrl;

   localparam int BUS_TIMEOUT = 20;
   localparam int IRQ_TIMEOUT = 12;

   logic        dsp_clk;
   logic        arst_n_i;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic        sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic [7:0]  periph_irq_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        int_o;
   logic [7:0]  leds_o;
   logic        clock_ready_o;
   logic [1:0]  clk_en_o;
   logic [1:0]  clk_sel_o;
   logic        ser_enable_o;
   logic        ser_prbsen_o;
   logic        ser_loopen_o;
   logic        ser_rx_en_o;
   logic        adc_oe_a_o;
   logic        adc_on_a_o;
   logic        adc_oe_b_o;
   logic        adc_on_b_o;
   logic        phy_reset_n_o;

   int          errors;
   int          checks;
   int          tests;
   int          test_base;
   logic [31:0] lcg_state;
   logic [31:0] rdata;
   logic        got_ack;
   logic        got_err;
   logic        seen;
   logic [31:0] data;
   logic        exp_phy_n;
   logic [4:0]  exp_clock;
   logic [3:0]  exp_serdes;
   logic [3:0]  exp_adc;
   logic [7:0]  exp_leds;
   logic [7:0]  led_sw;
   logic [7:0]  led_src;
   logic        hw_bit;

   u2_ctrl_top u2_ctrl_top_inst (.*);

   always #2 dsp_clk = ~dsp_clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Byte addresses for each slave
   function automatic logic [15:0] set_adr(input logic [7:0] a);
      return {u2_ctrl_pkg::SLV_SETTINGS_ADDR, a, 2'b00};
   endfunction

   function automatic logic [15:0] rb_adr(input logic [3:0] w);
      return {u2_ctrl_pkg::SLV_STATUS_ADDR, 4'b0, w, 2'b00};
   endfunction

   function automatic logic [15:0] pic_adr(input logic [1:0] r);
      return {u2_ctrl_pkg::SLV_PIC_ADDR, 6'b0, r, 2'b00};
   endfunction

   // Control words packed like the RB_CTRL readback word
   function automatic logic [31:0] ctrl_word(input logic [4:0] c, input logic [3:0] s,
                                             input logic [3:0] a);
      return {11'b0, c, 4'b0, s, 4'b0, a};
   endfunction

   function automatic logic [31:0] pins_word();
      return ctrl_word({clock_ready_o, clk_en_o, clk_sel_o},
                       {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o},
                       {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      checks++;
      assert (got == exp) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
         errors++;
      end
   endtask

   // One classic cycle, held until ack or err
   task automatic bus_access(input logic [15:0] addr, input logic we,
                             input logic [31:0] wdata);
      int cycles;
      cycles  = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      @(posedge dsp_clk);
      wb_adr_i <= addr;
      wb_dat_i <= wdata;
      wb_we_i  <= we;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      while (!got_ack && !got_err && cycles < BUS_TIMEOUT) begin
         @(negedge dsp_clk);
         got_ack = wb_ack_o;
         got_err = wb_err_o;
         rdata   = wb_dat_o;
         cycles++;
      end
      if (!got_ack && !got_err) begin
         $display("Timeout: no ack or err for bus address %h", addr);
         errors++;
      end
      @(posedge dsp_clk);
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [31:0] wdata);
      bus_access(addr, 1'b1, wdata);
      check_value("write ack", 32'd1, 32'(got_ack));
   endtask

   task automatic bus_read(input logic [15:0] addr);
      bus_access(addr, 1'b0, '0);
      check_value("read ack", 32'd1, 32'(got_ack));
   endtask

   task automatic wait_int(output logic hit);
      int cycles;
      cycles = 0;
      hit    = 1'b0;
      while (!hit && cycles < IRQ_TIMEOUT) begin
         @(negedge dsp_clk);
         hit = int_o;
         cycles++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %s done, %0d failure(s)", name, errors - test_base);
      test_base = errors;
   endtask

   initial begin
      dsp_clk          = 1'b0;
      arst_n_i         = 1'b0;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_we_i          = 1'b0;
      wb_stb_i         = 1'b0;
      wb_cyc_i         = 1'b0;
      sim_mode_i       = 1'b0;
      clock_divider_i  = '0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      periph_irq_i     = '0;
      errors           = 0;
      checks           = 0;
      tests            = 0;
      test_base        = 0;
      lcg_state        = 32'hcae3_78d2;
      exp_clock        = '0;
      exp_serdes       = '0;
      exp_adc          = '0;
      exp_leds         = '0;
      repeat (16) @(posedge dsp_clk);
      arst_n_i <= 1'b1;

      @(negedge dsp_clk);
      check_value("reset leds", 32'h0, 32'(leds_o));
      check_value("reset int", 32'h0, 32'(int_o));
      check_value("reset pins", 32'h0, pins_word());
      check_value("reset ack/err", 32'h0, 32'({wb_ack_o, wb_err_o}));
      check_value("reset phy_reset_n", 32'h1, 32'(phy_reset_n_o));
      end_test("after_reset");

      ////////////////////////////////////////////////////////////
      // Setting writes reach the pins one cycle after ack
      ////////////////////////////////////////////////////////////
      data      = next_rand();
      exp_clock = data[4:0];
      bus_write(set_adr(u2_ctrl_pkg::SR_CLOCK), data);
      @(negedge dsp_clk);
      check_value("clock pins", ctrl_word(exp_clock, exp_serdes, exp_adc), pins_word());
      data       = next_rand();
      exp_serdes = data[3:0];
      bus_write(set_adr(u2_ctrl_pkg::SR_SERDES), data);
      @(negedge dsp_clk);
      check_value("serdes pins", ctrl_word(exp_clock, exp_serdes, exp_adc), pins_word());
      data    = next_rand();
      exp_adc = data[3:0];
      bus_write(set_adr(u2_ctrl_pkg::SR_ADC), data);
      @(negedge dsp_clk);
      check_value("adc pins", ctrl_word(exp_clock, exp_serdes, exp_adc), pins_word());
      data      = next_rand();
      exp_phy_n = ~data[0];
      bus_write(set_adr(u2_ctrl_pkg::SR_PHY), data);
      @(negedge dsp_clk);
      check_value("phy_reset_n", {31'b0, exp_phy_n}, {31'b0, phy_reset_n_o});
      // Unused setting address leaves every pin alone
      bus_write(set_adr(8'd5), next_rand());
      @(negedge dsp_clk);
      check_value("addr 5 pins", ctrl_word(exp_clock, exp_serdes, exp_adc), pins_word());
      check_value("addr 5 phy/leds", {23'b0, exp_phy_n, exp_leds},
                  {23'b0, phy_reset_n_o, leds_o});
      end_test("setting_writes");

      repeat (4) begin
         data    = next_rand();
         led_sw  = data[7:0];
         data    = next_rand();
         led_src = data[7:0];
         data    = next_rand();
         bus_write(set_adr(u2_ctrl_pkg::SR_LED_SW), {24'b0, led_sw});
         bus_write(set_adr(u2_ctrl_pkg::SR_LED_SRC), {24'b0, led_src});
         @(posedge dsp_clk);
         clk_status_i     <= data[0];
         serdes_link_up_i <= data[1];
         @(negedge dsp_clk);
         for (int i = 0; i < 8; i++) begin
            hw_bit      = (i == 1) ? data[0] : ((i == 0) ? data[1] : 1'b0);
            exp_leds[i] = led_src[i] ? hw_bit : led_sw[i];
         end
         check_value("leds", 32'(exp_leds), 32'(leds_o));
      end
      end_test("led_mux");

      @(posedge dsp_clk);
      data = next_rand();
      sim_mode_i      <= data[31];
      clock_divider_i <= data[3:0];
      bus_read(rb_adr(4'(u2_ctrl_pkg::RB_MODE)));
      check_value("RB_MODE", {data[31], 27'b0, data[3:0]}, rdata);
      bus_read(rb_adr(4'(u2_ctrl_pkg::RB_LEDS)));
      check_value("RB_LEDS", {24'b0, exp_leds}, rdata);
      bus_read(rb_adr(4'(u2_ctrl_pkg::RB_CTRL)));
      check_value("RB_CTRL", ctrl_word(exp_clock, exp_serdes, exp_adc), rdata);
      bus_read(rb_adr(4'd7));
      check_value("word 7", 32'h0, rdata);
      end_test("readback");

      bus_access(16'h0000, 1'b0, '0);
      check_value("unmapped err", 32'h1, 32'(got_err));
      check_value("unmapped ack", 32'h0, 32'(got_ack));
      end_test("unmapped");

      ////////////////////////////////////////////////////////////
      // Interrupt controller
      ////////////////////////////////////////////////////////////
      @(posedge dsp_clk);
      clk_status_i     <= 1'b0;
      serdes_link_up_i <= 1'b0;
      bus_write(pic_adr(u2_ctrl_pkg::PIC_EDGE), 32'h3ff);
      bus_write(pic_adr(u2_ctrl_pkg::PIC_MASK), 32'h3fb);
      bus_write(pic_adr(u2_ctrl_pkg::PIC_PENDING), 32'h3ff);
      @(negedge dsp_clk);
      check_value("int idle", 32'h0, 32'(int_o));
      @(posedge dsp_clk);
      periph_irq_i[2] <= 1'b1;
      wait_int(seen);
      if (!seen) begin
         $display("Timeout: int_o did not rise for unmasked line 2");
         errors++;
      end
      bus_read(pic_adr(u2_ctrl_pkg::PIC_PENDING));
      check_value("pending line 2", 32'h4, rdata);
      bus_write(pic_adr(u2_ctrl_pkg::PIC_PENDING), 32'h4);
      @(negedge dsp_clk);
      check_value("int after clear", 32'h0, 32'(int_o));
      // Line 3 stays masked
      @(posedge dsp_clk);
      periph_irq_i[3] <= 1'b1;
      wait_int(seen);
      check_value("masked line 3 int", 32'h0, 32'(seen));
      // Active-low PHY line
      @(posedge dsp_clk);
      periph_irq_i[4] <= 1'b1;
      bus_write(pic_adr(u2_ctrl_pkg::PIC_POLARITY), 32'h10);
      bus_write(pic_adr(u2_ctrl_pkg::PIC_MASK), 32'h3ef);
      bus_write(pic_adr(u2_ctrl_pkg::PIC_PENDING), 32'h3ff);
      @(posedge dsp_clk);
      periph_irq_i[4] <= 1'b0;
      wait_int(seen);
      if (!seen) begin
         $display("Timeout: int_o did not rise for active-low line 4");
         errors++;
      end
      bus_read(pic_adr(u2_ctrl_pkg::PIC_PENDING));
      check_value("pending line 4", 32'h10, rdata);
      end_test("interrupts");

      errors += u2_ctrl_top_inst.u2_ctrl_asserts_inst.fail_count;
      $display("Tests: %0d, checks: %0d, failures: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- verification/u2_ctrl_asserts.sv
////////////////////////////////////////////////////////////
// Bus response and interrupt checks on the control top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u2_ctrl_asserts (
   input logic dsp_clk,
   input logic arst_n_i,
   input logic stb_i,
   input logic cyc_i,
   input logic ack_i,
   input logic err_i,
   input logic int_i
);

   logic req;
   logic resp;
   int   fail_count = 0;

   assign req  = stb_i & cyc_i;
   assign resp = ack_i | err_i;

   // One kind of response at a time
   a_resp_excl: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      !(ack_i && err_i)) else begin
      $error("ack and err high in the same cycle");
      fail_count++;
   end

   a_resp_single: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      resp |=> !resp) else begin
      $error("bus response high in two consecutive cycles");
      fail_count++;
   end

   // Response follows the first sampled request by one cycle
   a_resp_delay: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      resp |-> ($past(req) && !$past(req, 2))) else begin
      $error("bus response not one cycle after the request rose");
      fail_count++;
   end

   a_int_reset: assert property (@(posedge dsp_clk) !arst_n_i |-> !int_i) else begin
      $error("int_o high while in reset");
      fail_count++;
   end

endmodule

bind u2_ctrl_top u2_ctrl_asserts u2_ctrl_asserts_inst (
   .dsp_clk  (dsp_clk),
   .arst_n_i (arst_n_i),
   .stb_i    (wb_stb_i),
   .cyc_i    (wb_cyc_i),
   .ack_i    (wb_ack_o),
   .err_i    (wb_err_o),
   .int_i    (int_o)
);

//--- verilog.f
verilog/u2_ctrl_pkg.sv
verilog/wb_if.sv
verilog/wb_decoder.sv
verilog/settings_bus.sv
verilog/control_regs.sv
verilog/readback_mux.sv
verilog/simple_pic.sv
verilog/u2_ctrl_top.sv
verification/u2_ctrl_asserts.sv
verification/tb_u2_ctrl.sv

//--- verilog/control_regs.sv
////////////////////////////////////////////////////////////
// Board control setting registers
// Clock gen, SERDES, ADC and PHY pins plus the LED mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module control_regs (
   input  logic                           dsp_clk,
   input  logic                           arst_n_i,
   input  logic                           set_stb_i,
   input  logic [u2_ctrl_pkg::SET_AW-1:0] set_addr_i,
   input  logic [u2_ctrl_pkg::WB_DW-1:0]  set_data_i,
   input  logic                           clk_status_i,
   input  logic                           serdes_link_up_i,
   output logic [4:0]                     clock_ctrl_o,
   output logic [3:0]                     serdes_ctrl_o,
   output logic [3:0]                     adc_ctrl_o,
   output logic                           phy_reset_n_o,
   output logic [7:0]                     leds_o
);

   logic [4:0] clock_q;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_reset_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////
   // Setting registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            u2_ctrl_pkg::SR_CLOCK:   clock_q     <= set_data_i[4:0];
            u2_ctrl_pkg::SR_SERDES:  serdes_q    <= set_data_i[3:0];
            u2_ctrl_pkg::SR_ADC:     adc_q       <= set_data_i[3:0];
            u2_ctrl_pkg::SR_PHY:     phy_reset_q <= set_data_i[0];
            u2_ctrl_pkg::SR_LED_SW:  led_sw_q    <= set_data_i[7:0];
            u2_ctrl_pkg::SR_LED_SRC: led_src_q   <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   assign clock_ctrl_o  = clock_q;
   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset_q;

   ////////////////////////////////////////////////////////////
   // LED source mux
   ////////////////////////////////////////////////////////////

   // Hardware status bits, upper LEDs have no hardware source
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};

   // Source bit 1 selects hardware, 0 selects software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

//--- verilog/readback_mux.sv
////////////////////////////////////////////////////////////
// Status readback slave, sixteen read-only words
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module readback_mux (
   input  logic       dsp_clk,
   input  logic       arst_n_i,
   wb_if.slave        bus,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i,
   input  logic [7:0] leds_i,
   input  logic [4:0] clock_ctrl_i,
   input  logic [3:0] serdes_ctrl_i,
   input  logic [3:0] adc_ctrl_i
);

   logic [u2_ctrl_pkg::WB_DW-1:0] words [u2_ctrl_pkg::RB_WORDS];
   logic [u2_ctrl_pkg::WB_DW-1:0] dat_q;
   logic                          req;
   logic                          ack_q;

   // Word map, unused words read zero
   always_comb begin
      words = '{default: '0};
      words[u2_ctrl_pkg::RB_MODE] = {sim_mode_i, 27'b0, clock_divider_i};
      words[u2_ctrl_pkg::RB_LEDS] = {24'b0, leds_i};
      words[u2_ctrl_pkg::RB_CTRL] = {11'b0, clock_ctrl_i, 4'b0, serdes_ctrl_i,
                                     4'b0, adc_ctrl_i};
   end

   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   // Data lands together with ack, writes only get an ack
   always_ff @(posedge dsp_clk) begin
      if (req) begin
         dat_q <= words[bus.adr[5:2]];
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

endmodule

//--- verilog/settings_bus.sv
////////////////////////////////////////////////////////////
// Settings bus slave
// Turns Wishbone writes into setting strobes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module settings_bus (
   input  logic                          dsp_clk,
   input  logic                          arst_n_i,
   wb_if.slave                           bus,
   output logic                          set_stb_o,
   output logic [u2_ctrl_pkg::SET_AW-1:0] set_addr_o,
   output logic [u2_ctrl_pkg::WB_DW-1:0] set_data_o
);

   logic                          req;
   logic                          ack_q;
   logic                          stb_q;
   logic [u2_ctrl_pkg::SET_AW-1:0] addr_q;
   logic [u2_ctrl_pkg::WB_DW-1:0] data_q;

   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= req;
         stb_q <= req & bus.we;
      end
   end

   // Word address and data, captured with the request
   always_ff @(posedge dsp_clk) begin
      if (req) begin
         addr_q <= bus.adr[u2_ctrl_pkg::SET_AW+1:2];
         data_q <= bus.dat_w;
      end
   end

   assign bus.ack    = ack_q;
   assign bus.dat_r  = '0;
   assign set_stb_o  = stb_q;
   assign set_addr_o = addr_q;
   assign set_data_o = data_q;

endmodule

//--- verilog/simple_pic.sv
////////////////////////////////////////////////////////////
// Interrupt controller slave
// Per-line edge/level, polarity, mask and pending bits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module simple_pic #(
   parameter int n_irq = 10
) (
   input  logic             dsp_clk,
   input  logic             arst_n_i,
   wb_if.slave              bus,
   input  logic [n_irq-1:0] irq_i,
   output logic             int_o
);

   u2_ctrl_pkg::pic_reg_e         reg_sel;
   logic [n_irq-1:0]              edge_q;
   logic [n_irq-1:0]              polarity_q;
   logic [n_irq-1:0]              mask_q;
   logic [n_irq-1:0]              pending;
   logic [u2_ctrl_pkg::WB_DW-1:0] rd_word;
   logic [u2_ctrl_pkg::WB_DW-1:0] dat_q;
   logic                          req;
   logic                          wr;
   logic                          ack_q;

   assign reg_sel = u2_ctrl_pkg::pic_reg_e'(bus.adr[3:2]);
   assign req     = bus.cyc & bus.stb & ~ack_q;
   assign wr      = req & bus.we;

   ////////////////////////////////////////////////////////////
   // Bus side, control registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q      <= 1'b0;
         edge_q     <= '0;
         polarity_q <= '0;
         mask_q     <= '0;
      end else begin
         ack_q <= req;
         if (wr && reg_sel == u2_ctrl_pkg::PIC_EDGE)     edge_q     <= bus.dat_w[n_irq-1:0];
         if (wr && reg_sel == u2_ctrl_pkg::PIC_POLARITY) polarity_q <= bus.dat_w[n_irq-1:0];
         if (wr && reg_sel == u2_ctrl_pkg::PIC_MASK)     mask_q     <= bus.dat_w[n_irq-1:0];
      end
   end

   always_comb begin
      rd_word = '0;
      case (reg_sel)
         u2_ctrl_pkg::PIC_EDGE:     rd_word[n_irq-1:0] = edge_q;
         u2_ctrl_pkg::PIC_POLARITY: rd_word[n_irq-1:0] = polarity_q;
         u2_ctrl_pkg::PIC_MASK:     rd_word[n_irq-1:0] = mask_q;
         default:                   rd_word[n_irq-1:0] = pending;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (req) begin
         dat_q <= rd_word;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

   ////////////////////////////////////////////////////////////
   // Per-line capture and pending
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < n_irq; i++) begin : g_line
      logic act_q;
      logic act_d;
      logic hit;
      logic pend_q;

      // Edge mode fires once per rise of the active level
      assign hit = edge_q[i] ? (act_q & ~act_d) : act_q;

      always_ff @(posedge dsp_clk or negedge arst_n_i) begin
         if (!arst_n_i) begin
            act_q  <= 1'b0;
            act_d  <= 1'b0;
            pend_q <= 1'b0;
         end else begin
            act_q  <= irq_i[i] ^ polarity_q[i];
            act_d  <= act_q;
            // New hit beats a clear in the same cycle
            pend_q <= hit | (pend_q & ~(wr && reg_sel == u2_ctrl_pkg::PIC_PENDING
                                        && bus.dat_w[i]));
         end
      end

      assign pending[i] = pend_q;
   end

   // Mask bit 1 hides the line
   assign int_o = |(pending & ~mask_q);

endmodule

//--- verilog/u2_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Board control package
// Bus widths, address map and register encodings
////////////////////////////////////////////////////////////

package u2_ctrl_pkg;

   // Wishbone bus geometry, byte addressed
   localparam int WB_AW    = 16;
   localparam int WB_DW    = 32;
   localparam int DECODE_W = 6;

   // Slave decode codes on the top address bits
   localparam logic [DECODE_W-1:0] SLV_STATUS_ADDR   = 6'b110011;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS_ADDR = 6'b110101;
   localparam logic [DECODE_W-1:0] SLV_PIC_ADDR      = 6'b110110;

   typedef enum logic [1:0] {
      SLV_STATUS,
      SLV_SETTINGS,
      SLV_PIC,
      SLV_NONE
   } wb_slave_e;

   // Settings bus
   localparam int SET_AW = 8;

   typedef enum logic [SET_AW-1:0] {
      SR_CLOCK   = 8'd0,
      SR_SERDES  = 8'd1,
      SR_ADC     = 8'd2,
      SR_LED_SW  = 8'd3,
      SR_PHY     = 8'd4,
      SR_LED_SRC = 8'd8
   } set_addr_e;

   // Interrupt controller registers, by word index
   typedef enum logic [1:0] {
      PIC_EDGE     = 2'd0,
      PIC_POLARITY = 2'd1,
      PIC_MASK     = 2'd2,
      PIC_PENDING  = 2'd3
   } pic_reg_e;

   localparam int NUM_IRQ = 10;

   // Status readback words
   localparam int RB_WORDS = 16;
   localparam int RB_MODE  = 0;
   localparam int RB_LEDS  = 1;
   localparam int RB_CTRL  = 2;

endpackage

//--- verilog/u2_ctrl_top.sv
////////////////////////////////////////////////////////////
// Board control top level
// Wishbone decode, settings, readback and interrupts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u2_ctrl_top (
   input  logic        dsp_clk,
   input  logic        arst_n_i,
   input  logic [15:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   input  logic        sim_mode_i,
   input  logic [3:0]  clock_divider_i,
   input  logic        clk_status_i,
   input  logic        serdes_link_up_i,
   input  logic [7:0]  periph_irq_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic        int_o,
   output logic [7:0]  leds_o,
   output logic        clock_ready_o,
   output logic [1:0]  clk_en_o,
   output logic [1:0]  clk_sel_o,
   output logic        ser_enable_o,
   output logic        ser_prbsen_o,
   output logic        ser_loopen_o,
   output logic        ser_rx_en_o,
   output logic        adc_oe_a_o,
   output logic        adc_on_a_o,
   output logic        adc_oe_b_o,
   output logic        adc_on_b_o,
   output logic        phy_reset_n_o
);

   wb_if host_wb ();
   wb_if status_wb ();
   wb_if settings_wb ();
   wb_if pic_wb ();

   logic                            set_stb;
   logic [u2_ctrl_pkg::SET_AW-1:0]  set_addr;
   logic [u2_ctrl_pkg::WB_DW-1:0]   set_data;
   logic [4:0]                      clock_ctrl;
   logic [3:0]                      serdes_ctrl;
   logic [3:0]                      adc_ctrl;
   logic [u2_ctrl_pkg::NUM_IRQ-1:0] irq;

   // Host port onto the bus
   assign host_wb.adr   = wb_adr_i;
   assign host_wb.dat_w = wb_dat_i;
   assign host_wb.we    = wb_we_i;
   assign host_wb.stb   = wb_stb_i;
   assign host_wb.cyc   = wb_cyc_i;
   assign wb_dat_o      = host_wb.dat_r;
   assign wb_ack_o      = host_wb.ack;

   wb_decoder wb_decoder_inst (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .host       (host_wb.slave),
      .status_o   (status_wb.master),
      .settings_o (settings_wb.master),
      .pic_o      (pic_wb.master),
      .err_o      (wb_err_o)
   );

   settings_bus settings_bus_inst (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .bus        (settings_wb.slave),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   control_regs control_regs_inst (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n_i),
      .set_stb_i        (set_stb),
      .set_addr_i       (set_addr),
      .set_data_i       (set_data),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl),
      .serdes_ctrl_o    (serdes_ctrl),
      .adc_ctrl_o       (adc_ctrl),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o)
   );

   readback_mux readback_mux_inst (
      .dsp_clk         (dsp_clk),
      .arst_n_i        (arst_n_i),
      .bus             (status_wb.slave),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .leds_i          (leds_o),
      .clock_ctrl_i    (clock_ctrl),
      .serdes_ctrl_i   (serdes_ctrl),
      .adc_ctrl_i      (adc_ctrl)
   );

   // Link and clock status sit above the peripheral lines
   assign irq = {clk_status_i, serdes_link_up_i, periph_irq_i};

   simple_pic #(
      .n_irq (u2_ctrl_pkg::NUM_IRQ)
   ) simple_pic_inst (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .bus      (pic_wb.slave),
      .irq_i    (irq),
      .int_o    (int_o)
   );

   // Control words to pins, MSB first
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;

endmodule

//--- verilog/wb_decoder.sv
////////////////////////////////////////////////////////////
// Wishbone address decoder for the board control slaves
// Unmapped space answers with a one-cycle error
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wb_decoder (
   input  logic dsp_clk,
   input  logic arst_n_i,
   wb_if.slave  host,
   wb_if.master status_o,
   wb_if.master settings_o,
   wb_if.master pic_o,
   output logic err_o
);

   u2_ctrl_pkg::wb_slave_e sel;
   logic                   req;
   logic                   err_q;

   // Compare top address bits
   always_comb begin
      case (host.adr[u2_ctrl_pkg::WB_AW-1 -: u2_ctrl_pkg::DECODE_W])
         u2_ctrl_pkg::SLV_STATUS_ADDR:   sel = u2_ctrl_pkg::SLV_STATUS;
         u2_ctrl_pkg::SLV_SETTINGS_ADDR: sel = u2_ctrl_pkg::SLV_SETTINGS;
         u2_ctrl_pkg::SLV_PIC_ADDR:      sel = u2_ctrl_pkg::SLV_PIC;
         default:                        sel = u2_ctrl_pkg::SLV_NONE;
      endcase
   end

   assign req = host.cyc & host.stb;

   // Request fan-out, strobe only to the selected slave
   assign status_o.adr     = host.adr;
   assign status_o.dat_w   = host.dat_w;
   assign status_o.we      = host.we;
   assign status_o.cyc     = host.cyc;
   assign status_o.stb     = host.stb & (sel == u2_ctrl_pkg::SLV_STATUS);

   assign settings_o.adr   = host.adr;
   assign settings_o.dat_w = host.dat_w;
   assign settings_o.we    = host.we;
   assign settings_o.cyc   = host.cyc;
   assign settings_o.stb   = host.stb & (sel == u2_ctrl_pkg::SLV_SETTINGS);

   assign pic_o.adr        = host.adr;
   assign pic_o.dat_w      = host.dat_w;
   assign pic_o.we         = host.we;
   assign pic_o.cyc        = host.cyc;
   assign pic_o.stb        = host.stb & (sel == u2_ctrl_pkg::SLV_PIC);

   // Response return from the selected slave
   always_comb begin
      case (sel)
         u2_ctrl_pkg::SLV_STATUS:   host.dat_r = status_o.dat_r;
         u2_ctrl_pkg::SLV_SETTINGS: host.dat_r = settings_o.dat_r;
         u2_ctrl_pkg::SLV_PIC:      host.dat_r = pic_o.dat_r;
         default:                   host.dat_r = '0;
      endcase
   end

   assign host.ack = status_o.ack | settings_o.ack | pic_o.ack;

   // Error pulse, never twice in a row
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & (sel == u2_ctrl_pkg::SLV_NONE) & ~err_q;
      end
   end

   assign err_o = err_q;

endmodule

//--- verilog/wb_if.sv
////////////////////////////////////////////////////////////
// Wishbone classic bus, single master
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface wb_if;

   logic [u2_ctrl_pkg::WB_AW-1:0] adr;
   logic [u2_ctrl_pkg::WB_DW-1:0] dat_w;
   logic [u2_ctrl_pkg::WB_DW-1:0] dat_r;
   logic                          we;
   logic                          stb;
   logic                          cyc;
   logic                          ack;

   // Bus owner side
   modport master (
      output adr, dat_w, we, stb, cyc,
      input  dat_r, ack
   );

   // Responder side
   modport slave (
      input  adr, dat_w, we, stb, cyc,
      output dat_r, ack
   );

endinterface
